//--- rtl/ppu_pkg.sv
// Post-processing shared definitions
`default_nettype none

package ppu_pkg;

  // ========================================
  // Pixel and setting types
  // ========================================

  typedef logic [7:0]  color_t;
  typedef logic [23:0] rgb_t;      // red high, green middle, blue low
  typedef logic [7:0]  rel_pos_t;
  typedef logic [7:0]  sl_level_t;
  typedef logic [17:0] cfg_word_t;

  // ========================================
  // Configuration word layout
  // ========================================

  localparam int LIMITED_RGB_BIT = 0;

  // Code widths of the scanline fields
  localparam int THICK_W = 2;
  localparam int STR_W   = 4;

  // 240p scanline set
  localparam int V240P_V_EN_BIT   = 1;
  localparam int V240P_H_EN_BIT   = 2;
  localparam int V240P_THICK_LSB  = 3;
  localparam int V240P_STR_LSB    = 5;

  // 480i scanline set
  localparam int V480I_V_EN_BIT   = 9;
  localparam int V480I_H_EN_BIT   = 10;
  localparam int V480I_THICK_LSB  = 11;
  localparam int V480I_STR_LSB    = 13;

  // 480i follows the 240p set when set
  localparam int LINKED_480I_BIT  = 17;

  // ========================================
  // Arithmetic and latency
  // ========================================

  localparam color_t LIMIT_COEFF  = 8'd220;
  localparam color_t LIMIT_OFFSET = 8'd16;

  localparam int SL_STAGE_LAT = 2;
  localparam int LIMIT_LAT    = 3;

endpackage

`default_nettype wire

//--- rtl/video_if.sv
// Pixel bus between pipeline stages
`timescale 1ns/10ps
`default_nettype none

interface video_if;
  import ppu_pkg::*;

  // One pixel per clock, no handshake
  logic vsync;
  logic hsync;
  logic de;
  rgb_t rgb;

  modport src (
    output vsync, hsync, de, rgb
  );

  modport snk (
    input vsync, hsync, de, rgb
  );

endinterface

`default_nettype wire

//--- rtl/ppu_cfg_decode.sv
// Scanline and range configuration decode
`timescale 1ns/10ps
`default_nettype none

module ppu_cfg_decode (
  input  logic                VCLK_Tx,
  input  logic                nVRST_Tx,
  input  ppu_pkg::cfg_word_t  config_i,
  input  logic                n64_480i_i,
  output ppu_pkg::sl_level_t  sl_thickness_o,
  output ppu_pkg::sl_level_t  sl_strength_o,
  output logic                sl_v_en_o,
  output logic                sl_h_en_o,
  output logic                limited_en_o
);
  import ppu_pkg::*;

  logic               use_240p;
  logic               sel_v_en;
  logic               sel_h_en;
  logic [THICK_W-1:0] sel_thick;
  logic [STR_W-1:0]   sel_str;
  sl_level_t          thick_exp;

  // Progressive input or linked 480i uses the 240p set
  assign use_240p = !n64_480i_i || config_i[LINKED_480I_BIT];

  always_comb begin
    if (use_240p) begin
      sel_v_en  = config_i[V240P_V_EN_BIT];
      sel_h_en  = config_i[V240P_H_EN_BIT];
      sel_thick = config_i[V240P_THICK_LSB +: THICK_W];
      sel_str   = config_i[V240P_STR_LSB +: STR_W];
    end else begin
      sel_v_en  = config_i[V480I_V_EN_BIT];
      sel_h_en  = config_i[V480I_H_EN_BIT];
      sel_thick = config_i[V480I_THICK_LSB +: THICK_W];
      sel_str   = config_i[V480I_STR_LSB +: STR_W];
    end

    // Thickness in 1/256 of a scaled line
    case (sel_thick)
      2'd1:    thick_exp = 8'h10;
      2'd2:    thick_exp = 8'h20;
      2'd3:    thick_exp = 8'h40;
      default: thick_exp = 8'h00;
    endcase
  end

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      sl_thickness_o <= '0;
      sl_strength_o  <= '0;
      sl_v_en_o      <= 1'b0;
      sl_h_en_o      <= 1'b0;
      limited_en_o   <= 1'b0;
    end else begin
      sl_thickness_o <= thick_exp;
      // (s+1)*16-1 is the code followed by four ones
      sl_strength_o  <= {sel_str, 4'hF};
      sl_v_en_o      <= sel_v_en;
      sl_h_en_o      <= sel_h_en;
      limited_en_o   <= config_i[LIMITED_RGB_BIT];
    end
  end

endmodule

`default_nettype wire

//--- rtl/scanline_emu.sv
// Scanline darkening stage
`timescale 1ns/10ps
`default_nettype none

module scanline_emu (
  input  logic               VCLK_Tx,
  input  logic               nVRST_Tx,
  video_if.snk               vid_i,
  video_if.src               vid_o,
  input  logic               sl_en_i,
  input  ppu_pkg::sl_level_t sl_thickness_i,
  input  ppu_pkg::sl_level_t sl_strength_i,
  input  ppu_pkg::rel_pos_t  sl_rel_pos_i,
  input  ppu_pkg::rel_pos_t  pass_pos_i,
  output ppu_pkg::rel_pos_t  pass_pos_o
);
  import ppu_pkg::*;

  // Sync and DE per stage, index 0 is the newest
  logic [SL_STAGE_LAT-1:0][2:0] ctl_q;
  logic                         on_sl_q;
  rgb_t                         rgb_q1;
  logic [2:0][15:0]             prod_q1;
  color_t [2:0]                 rgb_q2;
  rel_pos_t [SL_STAGE_LAT-1:0]  pos_q;

  // ========================================
  // Control path
  // ========================================

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      ctl_q   <= '0;
      on_sl_q <= 1'b0;
    end else begin
      ctl_q   <= {ctl_q[SL_STAGE_LAT-2:0], {vid_i.vsync, vid_i.hsync, vid_i.de}};
      // Inside the band when the position is below the thickness
      on_sl_q <= sl_en_i && (sl_rel_pos_i < sl_thickness_i);
    end
  end

  // ========================================
  // Colour path
  // ========================================

  always_ff @(posedge VCLK_Tx) begin
    rgb_q1 <= vid_i.rgb;
    pos_q  <= {pos_q[SL_STAGE_LAT-2:0], pass_pos_i};
    for (int i = 0; i < 3; i++) begin
      // Stage one: colour times strength
      prod_q1[i] <= vid_i.rgb[8*i +: 8] * sl_strength_i;
      // Stage two: subtract the scaled product on the band
      if (on_sl_q) begin
        rgb_q2[i] <= rgb_q1[8*i +: 8] - prod_q1[i][15:8];
      end else begin
        rgb_q2[i] <= rgb_q1[8*i +: 8];
      end
    end
  end

  assign vid_o.vsync = ctl_q[SL_STAGE_LAT-1][2];
  assign vid_o.hsync = ctl_q[SL_STAGE_LAT-1][1];
  assign vid_o.de    = ctl_q[SL_STAGE_LAT-1][0];
  assign vid_o.rgb   = rgb_q2;

  // Other stage's position, kept in step with its pixel
  assign pass_pos_o  = pos_q[SL_STAGE_LAT-1];

endmodule

`default_nettype wire

//--- rtl/rgb_range_limit.sv
// Limited range conversion and output registers
`timescale 1ns/10ps
`default_nettype none

module rgb_range_limit (
  input  logic          VCLK_Tx,
  input  logic          nVRST_Tx,
  video_if.snk          vid_i,
  input  logic          limited_en_i,
  output logic          vsync_o,
  output logic          hsync_o,
  output logic          de_o,
  output ppu_pkg::rgb_t vd_o
);
  import ppu_pkg::*;

  logic [2:0][15:0]          prod;
  logic [2:0][8:0]           p_q;
  color_t [2:0]              lim_q;
  rgb_t                      full_q1;
  rgb_t                      full_q2;
  rgb_t                      vd_q;
  logic [LIMIT_LAT-1:0][2:0] ctl_q;

  // Full-range colour scaled by 220/256
  always_comb begin
    for (int i = 0; i < 3; i++) begin
      prod[i] = vid_i.rgb[8*i +: 8] * LIMIT_COEFF;
    end
  end

  // ========================================
  // Three-stage pipeline
  // ========================================

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      p_q     <= '0;
      lim_q   <= '0;
      full_q1 <= '0;
      full_q2 <= '0;
      vd_q    <= '0;
      ctl_q   <= '0;
    end else begin
      ctl_q   <= {ctl_q[LIMIT_LAT-2:0], {vid_i.vsync, vid_i.hsync, vid_i.de}};
      full_q1 <= vid_i.rgb;
      full_q2 <= full_q1;
      for (int i = 0; i < 3; i++) begin
        // Top 9 bits of the product
        p_q[i]   <= prod[i][15:7];
        // Round half up
        lim_q[i] <= p_q[i][8:1] + p_q[i][0];
      end
      if (limited_en_i) begin
        for (int i = 0; i < 3; i++) begin
          vd_q[8*i +: 8] <= lim_q[i] + LIMIT_OFFSET;
        end
      end else begin
        vd_q <= full_q2;
      end
    end
  end

  assign vsync_o = ctl_q[LIMIT_LAT-1][2];
  assign hsync_o = ctl_q[LIMIT_LAT-1][1];
  assign de_o    = ctl_q[LIMIT_LAT-1][0];
  assign vd_o    = vd_q;

endmodule

`default_nettype wire

//--- rtl/ppu_post_top.sv
// Video post-processing top level
`timescale 1ns/10ps
`default_nettype none

module ppu_post_top (
  input  logic               VCLK_Tx,
  input  logic               nVRST_Tx,
  input  ppu_pkg::cfg_word_t config_i,
  input  logic               n64_480i_i,
  input  logic               vsync_i,
  input  logic               hsync_i,
  input  logic               de_i,
  input  ppu_pkg::rgb_t      vd_i,
  input  ppu_pkg::rel_pos_t  sl_hpos_rel_i,
  input  ppu_pkg::rel_pos_t  sl_vpos_rel_i,
  output logic               vsync_o,
  output logic               hsync_o,
  output logic               de_o,
  output ppu_pkg::rgb_t      vd_o
);
  import ppu_pkg::*;

  sl_level_t sl_thickness;
  sl_level_t sl_strength;
  logic      sl_v_en;
  logic      sl_h_en;
  logic      limited_en;
  rel_pos_t  vpos_dly;

  video_if v_in ();
  video_if v_sl1 ();
  video_if v_sl2 ();

  assign v_in.vsync = vsync_i;
  assign v_in.hsync = hsync_i;
  assign v_in.de    = de_i;
  assign v_in.rgb   = vd_i;

  ppu_cfg_decode u_cfg_decode (
    .VCLK_Tx        (VCLK_Tx),
    .nVRST_Tx       (nVRST_Tx),
    .config_i       (config_i),
    .n64_480i_i     (n64_480i_i),
    .sl_thickness_o (sl_thickness),
    .sl_strength_o  (sl_strength),
    .sl_v_en_o      (sl_v_en),
    .sl_h_en_o      (sl_h_en),
    .limited_en_o   (limited_en)
  );

  // ========================================
  // Scanline stages
  // ========================================

  // Vertical lines, driven by the horizontal position
  scanline_emu u_sl_vert (
    .VCLK_Tx        (VCLK_Tx),
    .nVRST_Tx       (nVRST_Tx),
    .vid_i          (v_in.snk),
    .vid_o          (v_sl1.src),
    .sl_en_i        (sl_v_en),
    .sl_thickness_i (sl_thickness),
    .sl_strength_i  (sl_strength),
    .sl_rel_pos_i   (sl_hpos_rel_i),
    .pass_pos_i     (sl_vpos_rel_i),
    .pass_pos_o     (vpos_dly)
  );

  // Horizontal lines, last stage carries nothing on
  scanline_emu u_sl_horz (
    .VCLK_Tx        (VCLK_Tx),
    .nVRST_Tx       (nVRST_Tx),
    .vid_i          (v_sl1.snk),
    .vid_o          (v_sl2.src),
    .sl_en_i        (sl_h_en),
    .sl_thickness_i (sl_thickness),
    .sl_strength_i  (sl_strength),
    .sl_rel_pos_i   (vpos_dly),
    .pass_pos_i     ('0),
    .pass_pos_o     ()
  );

  rgb_range_limit u_range_limit (
    .VCLK_Tx      (VCLK_Tx),
    .nVRST_Tx     (nVRST_Tx),
    .vid_i        (v_sl2.snk),
    .limited_en_i (limited_en),
    .vsync_o      (vsync_o),
    .hsync_o      (hsync_o),
    .de_o         (de_o),
    .vd_o         (vd_o)
  );

endmodule

`default_nettype wire

//--- test/tb_clkgen.sv
// Testbench clock and reset
`timescale 1ns/10ps
`default_nettype none

module tb_clkgen #(
  parameter int PERIOD_NS    = 4,
  parameter int RESET_CYCLES = 4
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Release just after an edge so no register sees it mid-sample
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1 rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

//--- test/ppu_post_asserts.sv
// Pipeline output checks
`timescale 1ns/10ps
`default_nettype none

module ppu_post_asserts (
  input logic          VCLK_Tx,
  input logic          nVRST_Tx,
  input logic          de_i,
  input logic          vsync_o,
  input logic          hsync_o,
  input logic          de_o,
  input ppu_pkg::rgb_t vd_o
);

  int         assert_fail_cnt = 0;
  logic [2:0] settle_cnt;

  // Cycles since reset release, saturating at the pipeline depth of 7
  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      settle_cnt <= '0;
    end else if (settle_cnt != 3'd7) begin
      settle_cnt <= settle_cnt + 3'd1;
    end
  end

  reset_outputs_low: assert property (@(posedge VCLK_Tx)
    !nVRST_Tx |-> (!vsync_o && !hsync_o && !de_o && vd_o == '0))
  else begin
    assert_fail_cnt++;
    $error("Outputs not cleared during reset");
  end

  de_latency: assert property (@(posedge VCLK_Tx) disable iff (!nVRST_Tx)
    (settle_cnt == 3'd7) |-> (de_o == $past(de_i, 7)))
  else begin
    assert_fail_cnt++;
    $error("de_o does not follow de_i after 7 cycles");
  end

endmodule

bind ppu_post_top ppu_post_asserts u_asserts (
  .VCLK_Tx  (VCLK_Tx),
  .nVRST_Tx (nVRST_Tx),
  .de_i     (de_i),
  .vsync_o  (vsync_o),
  .hsync_o  (hsync_o),
  .de_o     (de_o),
  .vd_o     (vd_o)
);

`default_nettype wire

//--- test/tb_ppu_post.sv
// Post-processing pipeline testbench
`timescale 1ns/10ps
`default_nettype none

module tb_ppu_post;
  import ppu_pkg::*;

  localparam int CLK_PERIOD_NS = 4;
  localparam int RESET_CYCLES  = 4;
  localparam int PIPE_LAT      = 7;
  localparam int CFG_WAIT      = 4;

  // Pixels per run
  localparam int N_PASS = 64;
  localparam int N_LIM  = 96;
  localparam int N_VERT = 48;
  localparam int N_SEL  = 48;
  localparam int N_BOTH = 96;
  localparam int N_COMB = 96;
  localparam int N_RUNS = 11;
  localparam int WATCHDOG_CYCLES = N_PASS + N_LIM + 4 * N_VERT + 3 * N_SEL + N_BOTH
                                   + N_COMB + N_RUNS * (PIPE_LAT + CFG_WAIT + 4) + 200;

  logic      clk;
  logic      rst_n;
  cfg_word_t config_i;
  logic      n64_480i_i;
  logic      vsync_i;
  logic      hsync_i;
  logic      de_i;
  rgb_t      vd_i;
  rel_pos_t  sl_hpos_rel_i;
  rel_pos_t  sl_vpos_rel_i;
  logic      vsync_o;
  logic      hsync_o;
  logic      de_o;
  rgb_t      vd_o;

  integer     seed;
  cfg_word_t  cur_cfg;
  logic       cur_480i;
  rgb_t       exp_vd_q[$];
  logic [2:0] exp_ctl_q[$];

  tb_clkgen #(.PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(RESET_CYCLES)) u_clkgen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  ppu_post_top dut0 (
    .VCLK_Tx       (clk),
    .nVRST_Tx      (rst_n),
    .config_i      (config_i),
    .n64_480i_i    (n64_480i_i),
    .vsync_i       (vsync_i),
    .hsync_i       (hsync_i),
    .de_i          (de_i),
    .vd_i          (vd_i),
    .sl_hpos_rel_i (sl_hpos_rel_i),
    .sl_vpos_rel_i (sl_vpos_rel_i),
    .vsync_o       (vsync_o),
    .hsync_o       (hsync_o),
    .de_o          (de_o),
    .vd_o          (vd_o)
  );

  // ========================================
  // Reference model
  // ========================================

  function automatic int thickness_of(logic [1:0] code);
    case (code)
      2'd0:    return 0;
      2'd1:    return 16;
      2'd2:    return 32;
      default: return 64;
    endcase
  endfunction

  function automatic int limit_range(int c);
    int p;
    p = (c * 220) / 128;
    return p / 2 + p % 2 + 16;
  endfunction

  function automatic rgb_t expected_pixel(cfg_word_t cfg, logic is_480i, rgb_t px,
                                          rel_pos_t hpos, rel_pos_t vpos);
    int   lsb;
    int   thick;
    int   strength;
    int   c;
    int   ch;
    rgb_t res;
    // Field offset of the active set
    lsb = (is_480i && !cfg[LINKED_480I_BIT]) ? V480I_V_EN_BIT : V240P_V_EN_BIT;
    thick = thickness_of(cfg[lsb + 2 +: 2]);
    strength = (int'(cfg[lsb + 4 +: 4]) + 1) * 16 - 1;
    for (ch = 0; ch < 3; ch++) begin
      c = int'(px[8 * ch +: 8]);
      if (cfg[lsb] && int'(hpos) < thick) c = c - (c * strength) / 256;
      if (cfg[lsb + 1] && int'(vpos) < thick) c = c - (c * strength) / 256;
      if (cfg[LIMITED_RGB_BIT]) c = limit_range(c);
      res[8 * ch +: 8] = c[7:0];
    end
    return res;
  endfunction

  function automatic cfg_word_t pack_scanline_set(logic v_en, logic h_en, logic [1:0] thick,
                                                  logic [3:0] str, logic set_480i);
    cfg_word_t cfg;
    int        lsb;
    cfg = '0;
    lsb = set_480i ? V480I_V_EN_BIT : V240P_V_EN_BIT;
    cfg[lsb] = v_en;
    cfg[lsb + 1] = h_en;
    cfg[lsb + 2 +: 2] = thick;
    cfg[lsb + 4 +: 4] = str;
    return cfg;
  endfunction

  // ========================================
  // Drive and check
  // ========================================

  task automatic check_value(input string test_name, input string field,
                             input logic [31:0] expected, input logic [31:0] actual);
    if (actual !== expected) begin
      $display("FAIL %s %s: expected %0h, actual %0h", test_name, field, expected, actual);
      $display("TEST FAIL");
      $fatal(1, "Output mismatch in %s", test_name);
    end
  endtask

  task automatic drive_pixel(logic vs, logic hs, logic de, rgb_t px,
                             rel_pos_t hpos, rel_pos_t vpos);
    vsync_i = vs;
    hsync_i = hs;
    de_i = de;
    vd_i = px;
    sl_hpos_rel_i = hpos;
    sl_vpos_rel_i = vpos;
  endtask

  task automatic set_config(cfg_word_t cfg, logic is_480i);
    @(posedge clk);
    #1;
    config_i = cfg;
    n64_480i_i = is_480i;
    cur_cfg = cfg;
    cur_480i = is_480i;
    repeat (CFG_WAIT) @(posedge clk);
  endtask

  // Output of the pixel driven at step k is read at step k+7
  task automatic run_pixels(input string test_name, input int n);
    int         iter;
    int         r;
    int         r2;
    rgb_t       px;
    rel_pos_t   hpos;
    rel_pos_t   vpos;
    logic [2:0] ctl;
    for (iter = 0; iter < n + PIPE_LAT; iter++) begin
      @(posedge clk);
      #1;
      if (iter >= PIPE_LAT) begin
        check_value(test_name, "vd_o", 32'(exp_vd_q.pop_front()), 32'(vd_o));
        check_value(test_name, "sync/de", 32'(exp_ctl_q.pop_front()),
                    32'({vsync_o, hsync_o, de_o}));
      end
      if (iter < n) begin
        r = $random(seed);
        r2 = $random(seed);
        // Black and white lead every run
        px = (iter == 0) ? 24'h000000 : (iter == 1) ? 24'hffffff : r[23:0];
        ctl = r[26:24];
        hpos = {1'b0, r2[6:0]};
        vpos = {1'b0, r2[14:8]};
        exp_vd_q.push_back(expected_pixel(cur_cfg, cur_480i, px, hpos, vpos));
        exp_ctl_q.push_back(ctl);
        drive_pixel(ctl[2], ctl[1], ctl[0], px, hpos, vpos);
      end else begin
        drive_pixel(1'b0, 1'b0, 1'b0, '0, '0, '0);
      end
    end
  endtask

  // ========================================
  // Directed tests
  // ========================================

  task automatic test_reset_passthrough();
    int i;
    for (i = 0; i < 3; i++) begin
      @(posedge clk);
      #1;
      check_value("reset", "vd_o", 32'h0, 32'(vd_o));
      check_value("reset", "sync/de", 32'h0, 32'({vsync_o, hsync_o, de_o}));
    end
    // Widest and strongest fields, but both enables off
    set_config(pack_scanline_set(1'b0, 1'b0, 2'd3, 4'hf, 1'b0)
               | pack_scanline_set(1'b0, 1'b0, 2'd3, 4'hf, 1'b1), 1'b0);
    run_pixels("passthrough", N_PASS);
  endtask

  task automatic test_limited_range();
    cfg_word_t cfg;
    cfg = '0;
    cfg[LIMITED_RGB_BIT] = 1'b1;
    set_config(cfg, 1'b0);
    run_pixels("limited", N_LIM);
  endtask

  task automatic test_vertical_scanline();
    int         code;
    logic [3:0] str;
    for (code = 0; code < 4; code++) begin
      str = 4'($random(seed));
      set_config(pack_scanline_set(1'b1, 1'b0, 2'(code), str, 1'b0), 1'b0);
      run_pixels($sformatf("vertical_t%0d", code), N_VERT);
    end
  endtask

  task automatic test_setting_select();
    cfg_word_t cfg;
    cfg = pack_scanline_set(1'b1, 1'b0, 2'd3, 4'hf, 1'b0)
          | pack_scanline_set(1'b0, 1'b1, 2'd1, 4'h7, 1'b1);
    set_config(cfg, 1'b1);
    run_pixels("select_480i", N_SEL);
    cfg[LINKED_480I_BIT] = 1'b1;
    set_config(cfg, 1'b1);
    run_pixels("select_linked", N_SEL);
    cfg[LINKED_480I_BIT] = 1'b0;
    set_config(cfg, 1'b0);
    run_pixels("select_240p", N_SEL);
  endtask

  task automatic test_both_stages();
    set_config(pack_scanline_set(1'b1, 1'b1, 2'd3, 4'($random(seed)), 1'b0), 1'b0);
    run_pixels("both_stages", N_BOTH);
  endtask

  task automatic test_combined();
    cfg_word_t cfg;
    cfg = pack_scanline_set(1'b1, 1'b1, 2'd2, 4'ha, 1'b0);
    cfg[LIMITED_RGB_BIT] = 1'b1;
    set_config(cfg, 1'b0);
    run_pixels("combined", N_COMB);
  endtask

  // ========================================
  // Sequence and watchdog
  // ========================================

  initial begin
    seed = 32'h80f2_ca24;
    config_i = '0;
    n64_480i_i = 1'b0;
    cur_cfg = '0;
    cur_480i = 1'b0;
    drive_pixel(1'b0, 1'b0, 1'b0, '0, '0, '0);
    @(posedge rst_n);
    test_reset_passthrough();
    test_limited_range();
    test_vertical_scanline();
    test_setting_select();
    test_both_stages();
    test_combined();
    repeat (2) @(posedge clk);
    if (dut0.u_asserts.assert_fail_cnt == 0) begin
      $display("TEST PASS");
      $finish;
    end else begin
      $display("TEST FAIL");
      $fatal(1, "Bound assertions failed %0d times", dut0.u_asserts.assert_fail_cnt);
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD_NS);
    $display("Timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("TEST FAIL");
    $fatal(1, "Simulation timed out");
  end

endmodule

`default_nettype wire

//--- all.f
rtl/ppu_pkg.sv
rtl/video_if.sv
rtl/ppu_cfg_decode.sv
rtl/scanline_emu.sv
rtl/rgb_range_limit.sv
rtl/ppu_post_top.sv
test/tb_clkgen.sv
test/ppu_post_asserts.sv
test/tb_ppu_post.sv

//--- Makefile
# Verilator build and run of the post-processing testbench
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
LINTFLAGS = --lint-only --timing --assert -Wall
TOP       = tb_ppu_post
RTL_TOP   = ppu_post_top
FILELIST  = all.f
OBJ_DIR   = obj_dir
SIM_ARGS  = +verilator+error+limit+100

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Pass only when the pass message appears on a line of its own
run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
